//--- design/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// datapath widths
`define WORD_W      32
`define REG_ADDR_W  5
`define ALUOP_W     8
`define ALUTYPE_W   3
`define EXC_W       5

// boot vector
`define PC_INIT     32'hbfc0_0000

// link register for jal and the linking branches
`define REG_RA      5'd31

`endif

//--- design/id_pkg.sv
`include "id_macros.svh"

package id_pkg;

    typedef enum logic [`ALUTYPE_W-1:0] {
        ALU_NONE  = 3'b000,
        ALU_ARITH = 3'b001,
        ALU_LOGIC = 3'b010,
        ALU_MOVE  = 3'b011,
        ALU_SHIFT = 3'b100,
        ALU_JUMP  = 3'b101
    } alutype_e;

    // execute-stage operation codes
    typedef enum logic [`ALUOP_W-1:0] {
        OP_NOP    = 8'h00, OP_LUI   = 8'h05, OP_SLL    = 8'h11, OP_SLLV   = 8'h12,
        OP_SUB    = 8'h16, OP_ADDU  = 8'h17, OP_ADD    = 8'h18, OP_ADDIU  = 8'h19,
        OP_ADDI   = 8'h1a, OP_SUBU  = 8'h1b, OP_AND    = 8'h1c, OP_ORI    = 8'h1d,
        OP_ANDI   = 8'h1e, OP_NOR   = 8'h1f, OP_OR     = 8'h20, OP_XOR    = 8'h21,
        OP_XORI   = 8'h22, OP_SLT   = 8'h26, OP_SLTIU  = 8'h27, OP_SLTI   = 8'h28,
        OP_SLTU   = 8'h29, OP_SRA   = 8'h2a, OP_SRAV   = 8'h2b, OP_SRL    = 8'h2c,
        OP_SRLV   = 8'h2d, OP_J     = 8'h30, OP_JR     = 8'h31, OP_JAL    = 8'h32,
        OP_BEQ    = 8'h34, OP_BNE   = 8'h38, OP_BGEZ   = 8'h40, OP_BGTZ   = 8'h41,
        OP_BLEZ   = 8'h42, OP_BLTZ  = 8'h44, OP_BLTZAL = 8'h48, OP_BGEZAL = 8'h49,
        OP_JALR   = 8'h4a, OP_SYSCALL = 8'h86, OP_BREAK = 8'h88, OP_LB    = 8'h90,
        OP_LBU    = 8'h91, OP_LW    = 8'h92, OP_LH     = 8'h94, OP_LHU    = 8'h96,
        OP_SB     = 8'h98, OP_SH    = 8'h99, OP_SW     = 8'h9a
    } aluop_e;

    typedef enum logic [`EXC_W-1:0] {
        EXC_NONE  = 5'h00,
        EXC_SYS   = 5'h08,
        EXC_BREAK = 5'h09,
        EXC_RI    = 5'h0a
    } exccode_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J, BR_JR
    } br_kind_e;

    typedef struct packed {
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] inst;
        logic               in_delay;
        exccode_e           exccode;
    } fetch_t;

    typedef struct packed {
        logic                   rreg1;
        logic [`REG_ADDR_W-1:0] ra1;
        logic                   rreg2;
        logic [`REG_ADDR_W-1:0] ra2;
    } rd_req_t;

    typedef struct packed {
        logic                   wreg;
        logic [`REG_ADDR_W-1:0] wa;
        logic [`WORD_W-1:0]     wd;
        logic                   mreg;   // wd is a load result, not ready yet
    } fwd_src_t;

    typedef struct packed {
        alutype_e               alutype;
        aluop_e                 aluop;
        logic                   wreg;
        logic                   mreg;
        logic [`REG_ADDR_W-1:0] wa;
        logic                   shift;
        logic                   immsel;
        logic                   jal;
        br_kind_e               br_kind;
    } ctrl_t;

    typedef struct packed {
        logic [1:0]         jtsel;
        logic [`WORD_W-1:0] jump_addr1;   // j, jal
        logic [`WORD_W-1:0] jump_addr2;   // taken branch
        logic [`WORD_W-1:0] jump_addr3;   // jr, jalr
    } redirect_t;

    typedef struct packed {
        alutype_e               alutype;
        aluop_e                 aluop;
        logic                   wreg;
        logic                   mreg;
        logic [`REG_ADDR_W-1:0] wa;
        logic [`WORD_W-1:0]     src1;
        logic [`WORD_W-1:0]     src2;
        logic [`WORD_W-1:0]     din;
        logic [`WORD_W-1:0]     pc;
        logic [`WORD_W-1:0]     ret_addr;
        logic                   in_delay;
        exccode_e               exccode;
    } idexe_t;

endpackage

//--- design/ifid_reg.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module ifid_reg (
    input  logic           cpu_clk_i,
    input  logic           rst_i,
    input  logic           stall_i,
    input  logic           flush_i,
    input  id_pkg::fetch_t fetch_i,
    output id_pkg::fetch_t fetch_o
);

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            fetch_o    <= '0;
            fetch_o.pc <= `PC_INIT;
        end else if (flush_i) begin
            // zero word decodes as sll r0, i.e. a no-op
            fetch_o    <= '0;
            fetch_o.pc <= fetch_i.pc;
        end else if (!stall_i) begin
            fetch_o <= fetch_i;
        end
    end

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module inst_decoder (
    input  id_pkg::fetch_t     fetch_i,
    output id_pkg::ctrl_t      ctrl_o,
    output id_pkg::rd_req_t    rd_req_o,
    output logic               src1_ovr_o,
    output logic [`WORD_W-1:0] src1_val_o,
    output logic               src2_ovr_o,
    output logic [`WORD_W-1:0] src2_val_o,
    output id_pkg::exccode_e   exccode_o
);
    import id_pkg::*;

    logic [5:0]             op;
    logic [5:0]             func;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] sa;
    logic [15:0]            imm;
    aluop_e                 aluop;
    logic                   is_load;
    logic                   is_store;
    logic                   is_logic;
    logic                   is_shift;
    logic                   imm_form;
    logic                   sext;
    logic                   link;
    logic                   writes;

    assign op   = fetch_i.inst[31:26];
    assign rs   = fetch_i.inst[25:21];
    assign rt   = fetch_i.inst[20:16];
    assign rd   = fetch_i.inst[15:11];
    assign sa   = fetch_i.inst[10:6];
    assign func = fetch_i.inst[5:0];
    assign imm  = fetch_i.inst[15:0];

    always_comb begin
        aluop = OP_NOP;   // unmatched opcodes stay reserved
        case (op)
            6'h00: begin
                case (func)
                    6'h00: aluop = OP_SLL;
                    6'h02: aluop = OP_SRL;
                    6'h03: aluop = OP_SRA;
                    6'h04: aluop = OP_SLLV;
                    6'h06: aluop = OP_SRLV;
                    6'h07: aluop = OP_SRAV;
                    6'h08: aluop = OP_JR;
                    6'h09: aluop = OP_JALR;
                    6'h0c: aluop = OP_SYSCALL;
                    6'h0d: aluop = OP_BREAK;
                    6'h20: aluop = OP_ADD;
                    6'h21: aluop = OP_ADDU;
                    6'h22: aluop = OP_SUB;
                    6'h23: aluop = OP_SUBU;
                    6'h24: aluop = OP_AND;
                    6'h25: aluop = OP_OR;
                    6'h26: aluop = OP_XOR;
                    6'h27: aluop = OP_NOR;
                    6'h2a: aluop = OP_SLT;
                    6'h2b: aluop = OP_SLTU;
                    default: aluop = OP_NOP;
                endcase
            end
            6'h01: begin   // regimm, kind sits in rt
                case (rt)
                    5'h00: aluop = OP_BLTZ;
                    5'h01: aluop = OP_BGEZ;
                    5'h10: aluop = OP_BLTZAL;
                    5'h11: aluop = OP_BGEZAL;
                    default: aluop = OP_NOP;
                endcase
            end
            6'h02: aluop = OP_J;
            6'h03: aluop = OP_JAL;
            6'h04: aluop = OP_BEQ;
            6'h05: aluop = OP_BNE;
            6'h06: aluop = (rt == '0) ? OP_BLEZ : OP_NOP;
            6'h07: aluop = (rt == '0) ? OP_BGTZ : OP_NOP;
            6'h08: aluop = OP_ADDI;
            6'h09: aluop = OP_ADDIU;
            6'h0a: aluop = OP_SLTI;
            6'h0b: aluop = OP_SLTIU;
            6'h0c: aluop = OP_ANDI;
            6'h0d: aluop = OP_ORI;
            6'h0e: aluop = OP_XORI;
            6'h0f: aluop = OP_LUI;
            6'h20: aluop = OP_LB;
            6'h21: aluop = OP_LH;
            6'h23: aluop = OP_LW;
            6'h24: aluop = OP_LBU;
            6'h25: aluop = OP_LHU;
            6'h28: aluop = OP_SB;
            6'h29: aluop = OP_SH;
            6'h2b: aluop = OP_SW;
            default: aluop = OP_NOP;
        endcase
    end

    assign is_load  = aluop inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    assign is_store = aluop inside {OP_SB, OP_SH, OP_SW};
    assign is_logic = aluop inside {OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ANDI, OP_ORI, OP_XORI,
                                    OP_LUI};
    assign is_shift = aluop inside {OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV};
    assign imm_form = is_load || is_store ||
                      aluop inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                    OP_XORI, OP_LUI};
    assign sext     = imm_form && !is_logic;
    assign link     = aluop inside {OP_JAL, OP_BGEZAL, OP_BLTZAL};
    assign writes   = !(is_store || aluop inside {OP_NOP, OP_J, OP_JR, OP_BEQ, OP_BNE, OP_BGEZ,
                                                  OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_SYSCALL,
                                                  OP_BREAK});

    always_comb begin
        ctrl_o.aluop  = aluop;
        ctrl_o.mreg   = is_load;
        ctrl_o.shift  = aluop inside {OP_SLL, OP_SRL, OP_SRA};
        ctrl_o.immsel = imm_form;
        ctrl_o.jal    = link;
        case (aluop)
            OP_BEQ:             ctrl_o.br_kind = BR_BEQ;
            OP_BNE:             ctrl_o.br_kind = BR_BNE;
            OP_BGEZ, OP_BGEZAL: ctrl_o.br_kind = BR_BGEZ;
            OP_BGTZ:            ctrl_o.br_kind = BR_BGTZ;
            OP_BLEZ:            ctrl_o.br_kind = BR_BLEZ;
            OP_BLTZ, OP_BLTZAL: ctrl_o.br_kind = BR_BLTZ;
            OP_J, OP_JAL:       ctrl_o.br_kind = BR_J;
            OP_JR, OP_JALR:     ctrl_o.br_kind = BR_JR;
            default:            ctrl_o.br_kind = BR_NONE;
        endcase
        if (imm_form && !is_store)
            ctrl_o.wa = rt;
        else if (link)
            ctrl_o.wa = `REG_RA;
        else
            ctrl_o.wa = rd;
        ctrl_o.wreg = writes && (ctrl_o.wa != '0);   // writes to r0 are dropped
        if (aluop inside {OP_NOP, OP_SYSCALL, OP_BREAK})
            ctrl_o.alutype = ALU_NONE;
        else if (ctrl_o.br_kind != BR_NONE)
            ctrl_o.alutype = ALU_JUMP;
        else if (is_shift)
            ctrl_o.alutype = ALU_SHIFT;
        else if (is_logic)
            ctrl_o.alutype = ALU_LOGIC;
        else
            ctrl_o.alutype = ALU_ARITH;
    end

    // rs always on port 1, rt on port 2
    assign rd_req_o.rreg1 = !(aluop inside {OP_NOP, OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_J, OP_JAL,
                                            OP_SYSCALL, OP_BREAK});
    assign rd_req_o.ra1   = rs;
    assign rd_req_o.rreg2 = is_store || aluop inside {OP_BEQ, OP_BNE} ||
                            (op == 6'h00 && !(aluop inside {OP_NOP, OP_JR, OP_JALR, OP_SYSCALL,
                                                            OP_BREAK}));
    assign rd_req_o.ra2   = rt;

    assign src1_ovr_o = ctrl_o.shift;
    assign src1_val_o = {{(`WORD_W-`REG_ADDR_W){1'b0}}, sa};
    assign src2_ovr_o = ctrl_o.immsel;
    assign src2_val_o = (aluop == OP_LUI) ? {imm, 16'h0000} :
                        sext ? {{(`WORD_W-16){imm[15]}}, imm} : {{(`WORD_W-16){1'b0}}, imm};

    always_comb begin
        if (aluop == OP_SYSCALL)
            exccode_o = EXC_SYS;
        else if (aluop == OP_BREAK)
            exccode_o = EXC_BREAK;
        else if (aluop == OP_NOP)
            exccode_o = EXC_RI;
        else
            exccode_o = fetch_i.exccode;
    end

endmodule

//--- design/operand_bypass.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module operand_bypass (
    input  id_pkg::rd_req_t    rd_req_i,
    input  logic [`WORD_W-1:0] rd1_i,
    input  logic [`WORD_W-1:0] rd2_i,
    input  id_pkg::fwd_src_t   exe_fwd_i,
    input  id_pkg::fwd_src_t   mem_fwd_i,
    input  logic               src1_ovr_i,
    input  logic [`WORD_W-1:0] src1_val_i,
    input  logic               src2_ovr_i,
    input  logic [`WORD_W-1:0] src2_val_i,
    output logic [`WORD_W-1:0] src1_o,
    output logic [`WORD_W-1:0] src2_o,
    output logic [`WORD_W-1:0] din_o,
    output logic               stall_o
);
    import id_pkg::*;

    logic [`WORD_W-1:0] byp1;
    logic [`WORD_W-1:0] byp2;

    function automatic logic hit(input logic en, input logic [`REG_ADDR_W-1:0] ra,
                                 input fwd_src_t fwd);
        return en && fwd.wreg && (fwd.wa == ra);
    endfunction

    // execute holds the younger write, so it wins over memory
    function automatic logic [`WORD_W-1:0] pick(input logic en,
                                                input logic [`REG_ADDR_W-1:0] ra,
                                                input logic [`WORD_W-1:0] rf,
                                                input fwd_src_t exe,
                                                input fwd_src_t mem);
        if (!en)
            return '0;
        if (hit(en, ra, exe))
            return exe.wd;
        if (hit(en, ra, mem))
            return mem.wd;
        return rf;
    endfunction

    assign byp1 = pick(rd_req_i.rreg1, rd_req_i.ra1, rd1_i, exe_fwd_i, mem_fwd_i);
    assign byp2 = pick(rd_req_i.rreg2, rd_req_i.ra2, rd2_i, exe_fwd_i, mem_fwd_i);

    assign src1_o = src1_ovr_i ? src1_val_i : byp1;   // shift amount
    assign src2_o = src2_ovr_i ? src2_val_i : byp2;   // immediate
    assign din_o  = byp2;

    // load data not available yet
    assign stall_o = (exe_fwd_i.mreg && (hit(rd_req_i.rreg1, rd_req_i.ra1, exe_fwd_i) ||
                                         hit(rd_req_i.rreg2, rd_req_i.ra2, exe_fwd_i))) ||
                     (mem_fwd_i.mreg && (hit(rd_req_i.rreg1, rd_req_i.ra1, mem_fwd_i) ||
                                         hit(rd_req_i.rreg2, rd_req_i.ra2, mem_fwd_i)));

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module branch_unit (
    input  id_pkg::fetch_t     fetch_i,
    input  id_pkg::ctrl_t      ctrl_i,
    input  logic [`WORD_W-1:0] src1_i,
    input  logic [`WORD_W-1:0] src2_i,
    output id_pkg::redirect_t  redirect_o,
    output logic               next_delay_o,
    output logic [`WORD_W-1:0] ret_addr_o
);
    import id_pkg::*;

    logic [`WORD_W-1:0] pc_plus4;
    logic [`WORD_W-1:0] br_offset;
    logic               negative;
    logic               zero;
    logic               taken;

    assign pc_plus4  = fetch_i.pc + `WORD_W'(4);
    assign br_offset = {{(`WORD_W-18){fetch_i.inst[15]}}, fetch_i.inst[15:0], 2'b00};
    assign negative  = src1_i[`WORD_W-1];
    assign zero      = (src1_i == '0);

    always_comb begin
        case (ctrl_i.br_kind)
            BR_BEQ:  taken = (src1_i == src2_i);
            BR_BNE:  taken = (src1_i != src2_i);
            BR_BGEZ: taken = !negative;
            BR_BGTZ: taken = !negative && !zero;
            BR_BLEZ: taken = negative || zero;
            BR_BLTZ: taken = negative;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o.jump_addr1 = {pc_plus4[`WORD_W-1 -: 4], fetch_i.inst[25:0], 2'b00};
    assign redirect_o.jump_addr2 = pc_plus4 + br_offset;
    assign redirect_o.jump_addr3 = src1_i;   // bypassed rs

    always_comb begin
        if (ctrl_i.br_kind == BR_J)
            redirect_o.jtsel = 2'b01;
        else if (ctrl_i.br_kind == BR_JR)
            redirect_o.jtsel = 2'b10;
        else if (taken)
            redirect_o.jtsel = 2'b11;
        else
            redirect_o.jtsel = 2'b00;
    end

    // the next word sits in the delay slot, taken or not
    assign next_delay_o = (ctrl_i.br_kind != BR_NONE);
    assign ret_addr_o   = pc_plus4 + `WORD_W'(4);

endmodule

//--- design/idexe_reg.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module idexe_reg (
    input  logic           cpu_clk_i,
    input  logic           rst_i,
    input  logic           stall_i,
    input  id_pkg::idexe_t payload_i,
    output id_pkg::idexe_t exe_o
);

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            exe_o    <= '0;
            exe_o.pc <= `PC_INIT;
        end else if (stall_i) begin
            exe_o <= '0;   // bubble while decode waits on a load
        end else begin
            exe_o <= payload_i;
        end
    end

endmodule

//--- design/id_top.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module id_top (
    input  logic               cpu_clk_i,
    input  logic               rst_i,
    input  logic               flush_i,
    input  id_pkg::fetch_t     fetch_i,
    input  logic [`WORD_W-1:0] rd1_i,
    input  logic [`WORD_W-1:0] rd2_i,
    input  id_pkg::fwd_src_t   exe_fwd_i,
    input  id_pkg::fwd_src_t   mem_fwd_i,
    output id_pkg::rd_req_t    rd_req_o,
    output id_pkg::redirect_t  redirect_o,
    output logic               next_delay_o,
    output logic               stall_o,
    output id_pkg::idexe_t     exe_o
);
    import id_pkg::*;

    fetch_t             fetch_q;
    ctrl_t              ctrl;
    logic               src1_ovr;
    logic [`WORD_W-1:0] src1_val;
    logic               src2_ovr;
    logic [`WORD_W-1:0] src2_val;
    exccode_e           exccode;
    logic [`WORD_W-1:0] src1;
    logic [`WORD_W-1:0] src2;
    logic [`WORD_W-1:0] din;
    logic [`WORD_W-1:0] ret_addr;
    idexe_t             payload;

    ifid_reg u_ifid (
        .cpu_clk_i (cpu_clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_o),
        .flush_i   (flush_i),
        .fetch_i   (fetch_i),
        .fetch_o   (fetch_q)
    );

    inst_decoder u_dec (
        .fetch_i    (fetch_q),
        .ctrl_o     (ctrl),
        .rd_req_o   (rd_req_o),
        .src1_ovr_o (src1_ovr),
        .src1_val_o (src1_val),
        .src2_ovr_o (src2_ovr),
        .src2_val_o (src2_val),
        .exccode_o  (exccode)
    );

    operand_bypass u_byp (
        .rd_req_i   (rd_req_o),
        .rd1_i      (rd1_i),
        .rd2_i      (rd2_i),
        .exe_fwd_i  (exe_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .src1_ovr_i (src1_ovr),
        .src1_val_i (src1_val),
        .src2_ovr_i (src2_ovr),
        .src2_val_i (src2_val),
        .src1_o     (src1),
        .src2_o     (src2),
        .din_o      (din),
        .stall_o    (stall_o)
    );

    branch_unit u_br (
        .fetch_i      (fetch_q),
        .ctrl_i       (ctrl),
        .src1_i       (src1),
        .src2_i       (src2),
        .redirect_o   (redirect_o),
        .next_delay_o (next_delay_o),
        .ret_addr_o   (ret_addr)
    );

    // execute payload from the decode results
    assign payload.alutype  = ctrl.alutype;
    assign payload.aluop    = ctrl.aluop;
    assign payload.wreg     = ctrl.wreg;
    assign payload.mreg     = ctrl.mreg;
    assign payload.wa       = ctrl.wa;
    assign payload.src1     = src1;
    assign payload.src2     = src2;
    assign payload.din      = din;
    assign payload.pc       = fetch_q.pc;
    assign payload.ret_addr = ret_addr;
    assign payload.in_delay = fetch_q.in_delay;
    assign payload.exccode  = exccode;

    idexe_reg u_idexe (
        .cpu_clk_i (cpu_clk_i),
        .rst_i     (rst_i),
        .stall_i   (stall_o),
        .payload_i (payload),
        .exe_o     (exe_o)
    );

endmodule

//--- tests/id_asserts.sv
`timescale 1ns/1ps

module id_asserts (
    input logic              cpu_clk_i,
    input logic              rst_i,
    input logic              stall_o,
    input logic              next_delay_o,
    input id_pkg::redirect_t redirect_o,
    input id_pkg::idexe_t    exe_o
);
    import id_pkg::*;

    a_reset_wreg: assert property (@(posedge cpu_clk_i) rst_i |=> !exe_o.wreg)
        else $error("exe_o.wreg set right after reset");

    a_stall_bubble: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        stall_o |=> (exe_o == '0))
        else $error("no bubble after a stall cycle");

    a_jump_delay: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        (redirect_o.jtsel != 2'b00) |-> next_delay_o)
        else $error("jump select without delay slot flag");

    a_ri_no_write: assert property (@(posedge cpu_clk_i)
        !(exe_o.exccode == EXC_RI && exe_o.wreg))
        else $error("reserved instruction writes a register");

endmodule

bind id_top id_asserts u_asserts (
    .cpu_clk_i    (cpu_clk_i),
    .rst_i        (rst_i),
    .stall_o      (stall_o),
    .next_delay_o (next_delay_o),
    .redirect_o   (redirect_o),
    .exe_o        (exe_o)
);

//--- tests/tb_id_top.sv
`timescale 1ns/1ps
`include "id_macros.svh"

module tb_id_top;
    import id_pkg::*;

    logic               cpu_clk_i;
    logic               rst_i;
    logic               flush_i;
    fetch_t             fetch_i;
    logic [`WORD_W-1:0] rd1_i;
    logic [`WORD_W-1:0] rd2_i;
    fwd_src_t           exe_fwd_i;
    fwd_src_t           mem_fwd_i;
    rd_req_t            rd_req_o;
    redirect_t          redirect_o;
    logic               next_delay_o;
    logic               stall_o;
    idexe_t             exe_o;

    integer      seed;
    int          fd;
    int          cnt;
    string       line;
    logic        delay_flag;
    logic [31:0] c_flush, c_inst, c_pc, c_fexc, c_rnd, c_rd1, c_rd2;
    logic [31:0] c_ew, c_ewa, c_ewd, c_em, c_mw, c_mwa, c_mwd, c_mm;
    logic [31:0] x_rdreq, x_stall, x_jtsel, x_target, x_ndly, x_wreg, x_wa;
    logic [31:0] x_src1, x_src2, x_din, x_exc;

    id_top DUT (.*);

    always #20 cpu_clk_i = ~cpu_clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "first mismatch");
        end
    endtask

    task automatic wait_stall_clear();
        int n;
        n = 0;
        while (stall_o) begin
            if (n == 16)
                abort_run("stall_o stayed high after the load result was cleared");
            n++;
            @(posedge cpu_clk_i);
            #2;
        end
    endtask

    task automatic check_payload();
        check("exe.wreg", 32'(exe_o.wreg), x_wreg);
        check("exe.wa", 32'(exe_o.wa), x_wa);
        check("exe.src1", exe_o.src1, x_src1);
        check("exe.src2", exe_o.src2, x_src2);
        check("exe.din", exe_o.din, x_din);
        check("exe.exccode", 32'(exe_o.exccode), x_exc);
        check("exe.pc", exe_o.pc, c_pc);
        check("exe.ret_addr", exe_o.ret_addr, c_pc + 32'd8);   // link is pc+8
        check("exe.in_delay", 32'(exe_o.in_delay),
              c_flush[0] ? 32'd0 : 32'(delay_flag));   // flushed word carries no flag
    endtask

    task automatic apply_case();
        delay_flag       = ~delay_flag;   // toggles per case
        fetch_i.pc       = c_pc;
        fetch_i.inst     = c_inst;
        fetch_i.in_delay = delay_flag;
        fetch_i.exccode  = exccode_e'(c_fexc[4:0]);
        flush_i          = c_flush[0];
        exe_fwd_i        = '0;
        mem_fwd_i        = '0;
        @(posedge cpu_clk_i);   // capture
        #1;
        flush_i = 1'b0;
        if (c_rnd[0]) begin
            c_rd1 = $random(seed);   // ports unused so any data will do
            c_rd2 = $random(seed);
        end
        rd1_i     = c_rd1;
        rd2_i     = c_rd2;
        exe_fwd_i = '{wreg: c_ew[0], wa: c_ewa[4:0], wd: c_ewd, mreg: c_em[0]};
        mem_fwd_i = '{wreg: c_mw[0], wa: c_mwa[4:0], wd: c_mwd, mreg: c_mm[0]};
        #1;
        check("rd_req", 32'(rd_req_o), x_rdreq);
        check("stall", 32'(stall_o), x_stall);
        check("jtsel", 32'(redirect_o.jtsel), x_jtsel);
        check("next_delay", 32'(next_delay_o), x_ndly);
        case (x_jtsel[1:0])
            2'b01: check("jump_addr1", redirect_o.jump_addr1, x_target);
            2'b10: check("jump_addr3", redirect_o.jump_addr3, x_target);
            2'b11: check("jump_addr2", redirect_o.jump_addr2, x_target);
            default: ;
        endcase
        if (x_stall[0]) begin
            @(posedge cpu_clk_i);
            #1;
            check("bubble", 32'(exe_o != '0), 32'd0);
            exe_fwd_i.mreg = 1'b0;   // load data now available
            mem_fwd_i.mreg = 1'b0;
            #1;
            wait_stall_clear();
        end
        @(posedge cpu_clk_i);
        #1;
        check_payload();
    endtask

    initial begin : watchdog
        repeat (2000) @(posedge cpu_clk_i);
        abort_run("simulation ran past its cycle limit");
    end

    initial begin
        cpu_clk_i  = 1'b0;
        rst_i      = 1'b1;
        flush_i    = 1'b0;
        fetch_i    = '0;
        rd1_i      = '0;
        rd2_i      = '0;
        exe_fwd_i  = '0;
        mem_fwd_i  = '0;
        delay_flag = 1'b0;
        seed       = 32'h8865c7c7;
        repeat (5) @(posedge cpu_clk_i);
        #1;
        rst_i = 1'b0;
        #1;
        check("reset wreg", 32'(exe_o.wreg), 32'd0);
        check("reset mreg", 32'(exe_o.mreg), 32'd0);
        check("reset pc", exe_o.pc, `PC_INIT);
        check("reset exccode", 32'(exe_o.exccode), 32'd0);
        check("reset stall", 32'(stall_o), 32'd0);
        check("reset jtsel", 32'(redirect_o.jtsel), 32'd0);
        check("reset next_delay", 32'(next_delay_o), 32'd0);
        fd = $fopen("tests/id_cases.txt", "r");
        if (fd == 0)
            abort_run("cannot open tests/id_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            cnt  = $fgets(line, fd);
            if (cnt == 0 || line.len() < 2 || line[0] == 8'h23)
                continue;   // comment or blank
            cnt = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                c_flush, c_inst, c_pc, c_fexc, c_rnd, c_rd1, c_rd2,
                c_ew, c_ewa, c_ewd, c_em, c_mw, c_mwa, c_mwd, c_mm,
                x_rdreq, x_stall, x_jtsel, x_target, x_ndly, x_wreg, x_wa,
                x_src1, x_src2, x_din, x_exc);
            if (cnt != 26)
                abort_run("a line in the case file has the wrong number of columns");
            apply_case();
        end
        $fclose(fd);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- tests/id_cases.txt
# flush inst pc fexc rnd rd1 rd2 ew ewa ewd em mw mwa mwd mm
# then expected: rdreq stall jtsel target ndly wreg wa src1 src2 din exc
0 00221820 00400100 0 0 11111111 22222222 0 0 0 0 0 0 0 0 862 0 0 0 0 1 3 11111111 22222222 22222222 0
0 2485fffc 00400104 0 0 11111111 22222222 0 0 0 0 0 0 0 0 905 0 0 0 0 1 5 11111111 fffffffc 0 0
0 34868001 00400108 0 0 11111111 22222222 0 0 0 0 0 0 0 0 906 0 0 0 0 1 6 11111111 8001 0 0
0 3c071234 0040010c 0 1 0 0 0 0 0 0 0 0 0 0 007 0 0 0 0 1 7 0 12340000 0 0
0 00024140 00400110 0 0 11111111 22222222 0 0 0 0 0 0 0 0 022 0 0 0 0 1 8 5 22222222 22222222 0
0 00221820 00400114 0 0 11111111 22222222 1 1 aaaa0001 0 1 1 bbbb0001 0 862 0 0 0 0 1 3 aaaa0001 22222222 22222222 0
0 00221820 00400114 0 0 11111111 22222222 1 5 cccc0005 0 1 2 bbbb0002 0 862 0 0 0 0 1 3 11111111 bbbb0002 bbbb0002 0
0 ac220008 00400118 0 0 11111111 22222222 0 0 0 0 1 2 dddd0002 0 862 0 0 0 0 0 0 11111111 8 dddd0002 0
0 00221820 0040011c 0 0 11111111 22222222 1 1 55550001 1 0 0 0 0 862 1 0 0 0 1 3 55550001 22222222 22222222 0
0 00221820 0040011c 0 0 11111111 22222222 0 0 0 0 1 2 66660002 1 862 1 0 0 0 1 3 11111111 66660002 66660002 0
0 10220004 00400100 0 0 12345678 12345678 0 0 0 0 0 0 0 0 862 0 3 00400114 1 0 0 12345678 12345678 12345678 0
0 10220004 00400100 0 0 1 2 0 0 0 0 0 0 0 0 862 0 0 0 1 0 0 1 2 2 0
0 1422fffe 00400100 0 0 1 2 0 0 0 0 0 0 0 0 862 0 3 004000fc 1 0 1f 1 2 2 0
0 1422fffe 00400100 0 0 7 7 0 0 0 0 0 0 0 0 862 0 0 0 1 0 1f 7 7 7 0
0 08123456 bfc00200 0 1 0 0 0 0 0 0 0 0 0 0 012 0 1 b048d158 1 0 6 0 0 0 0
0 01200008 00400100 0 0 00401000 0 0 0 0 0 0 0 0 0 a40 0 2 00401000 1 0 0 00401000 0 0 0
0 0c100040 00400100 0 1 0 0 0 0 0 0 0 0 0 0 010 0 1 00400100 1 1 1f 0 0 0 0
0 0000000c 00400100 0 1 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 0 8
0 0000000d 00400100 0 1 0 0 0 0 0 0 0 0 0 0 000 0 0 0 0 0 0 0 0 0 9
0 00220018 00400100 0 1 0 0 0 0 0 0 0 0 0 0 042 0 0 0 0 0 0 0 0 0 a
0 00221820 00400120 4 0 11111111 22222222 0 0 0 0 0 0 0 0 862 0 0 0 0 1 3 11111111 22222222 22222222 4
1 00221820 00400200 4 0 33333333 33333333 0 0 0 0 0 0 0 0 020 0 0 0 0 0 0 0 33333333 33333333 0

//--- compile.f
+incdir+design
design/id_pkg.sv
design/ifid_reg.sv
design/inst_decoder.sv
design/operand_bypass.sv
design/branch_unit.sv
design/idexe_reg.sv
design/id_top.sv
tests/id_asserts.sv
tests/tb_id_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
